// ==== hw/riscv_pkg.sv ====
`default_nettype none

package riscv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    typedef struct packed {
        funct7_t funct7;
        funct3_t funct3;
        opcode_t opcode;
    } alu_op_t;

    typedef struct packed {
        logic reg_write;
        logic alu_src_imm;  // second ALU operand comes from the immediate
        logic mem_read;
        logic mem_write;
        logic mem_to_reg;
        logic is_branch;
        logic is_jal;
        logic is_jalr;
        logic is_ecall;
    } ctrl_t;

    localparam opcode_t OP_ARITH     = 7'b0110011;
    localparam opcode_t OP_ARITH_IMM = 7'b0010011;
    localparam opcode_t OP_LOAD      = 7'b0000011;
    localparam opcode_t OP_STORE     = 7'b0100011;
    localparam opcode_t OP_BRANCH    = 7'b1100011;
    localparam opcode_t OP_JAL       = 7'b1101111;
    localparam opcode_t OP_JALR      = 7'b1100111;
    localparam opcode_t OP_SYSTEM    = 7'b1110011;

    localparam funct3_t F3_ADD = 3'b000;
    localparam funct3_t F3_SLL = 3'b001;
    localparam funct3_t F3_XOR = 3'b100;
    localparam funct3_t F3_SRL = 3'b101;
    localparam funct3_t F3_OR  = 3'b110;
    localparam funct3_t F3_AND = 3'b111;
    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;
    localparam funct3_t F3_BLT = 3'b100;
    localparam funct3_t F3_BGE = 3'b101;

    localparam funct7_t F7_SUB_SRA = 7'b0100000;

    localparam int NUM_REGS    = 32;
    localparam int IMEM_WORDS  = 64;
    localparam int DMEM_WORDS  = 64;
    localparam int IMEM_IDX_W  = $clog2(IMEM_WORDS);
    localparam int DMEM_IDX_W  = $clog2(DMEM_WORDS);

    localparam word_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  riscv_pkg::alu_op_t alu_op,
    input  riscv_pkg::word_t   alu_in_1,
    input  riscv_pkg::word_t   alu_in_2,
    output riscv_pkg::word_t   alu_result,
    output logic               alu_bcond
);
    import riscv_pkg::*;

    logic [4:0] shamt;
    logic       alt_funct;
    word_t      sum;
    word_t      diff;
    word_t      sra_val;

    assign shamt     = alu_in_2[4:0];
    assign alt_funct = (alu_op.funct7 == F7_SUB_SRA);
    assign sum       = alu_in_1 + alu_in_2;
    assign diff      = alu_in_1 - alu_in_2;
    assign sra_val   = word_t'($signed(alu_in_1) >>> shamt);

    always_comb begin
        alu_result = '0;
        alu_bcond  = 1'b0;
        case (alu_op.opcode)
            OP_ARITH, OP_ARITH_IMM: begin
                case (alu_op.funct3)
                    F3_ADD: begin
                        // immediate forms carry imm bits in funct7, so no subtract there
                        if (alu_op.opcode == OP_ARITH && alt_funct) begin
                            alu_result = diff;
                        end else begin
                            alu_result = sum;
                        end
                    end
                    F3_SLL:  alu_result = alu_in_1 << shamt;
                    F3_XOR:  alu_result = alu_in_1 ^ alu_in_2;
                    F3_SRL:  alu_result = alt_funct ? sra_val : (alu_in_1 >> shamt);
                    F3_OR:   alu_result = alu_in_1 | alu_in_2;
                    F3_AND:  alu_result = alu_in_1 & alu_in_2;
                    default: alu_result = '0;
                endcase
            end
            OP_LOAD, OP_STORE, OP_JALR: begin
                alu_result = sum;  // effective address or jump target
            end
            OP_BRANCH: begin
                case (alu_op.funct3)
                    F3_BEQ:  alu_bcond = (alu_in_1 == alu_in_2);
                    F3_BNE:  alu_bcond = (alu_in_1 != alu_in_2);
                    F3_BLT:  alu_bcond = ($signed(alu_in_1) < $signed(alu_in_2));
                    F3_BGE:  alu_bcond = ($signed(alu_in_1) >= $signed(alu_in_2));
                    default: alu_bcond = 1'b0;
                endcase
            end
            default: begin
                alu_result = '0;
                alu_bcond  = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  riscv_pkg::opcode_t opcode,
    output riscv_pkg::ctrl_t   ctrl
);
    import riscv_pkg::*;

    always_comb begin
        ctrl = '0;  // unknown opcodes fall through as a no-op
        case (opcode)
            OP_ARITH: begin
                ctrl.reg_write = 1'b1;
            end
            OP_ARITH_IMM: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_LOAD: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
            end
            OP_STORE: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
            end
            OP_BRANCH: begin
                ctrl.is_branch = 1'b1;
            end
            OP_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.is_jal    = 1'b1;
            end
            OP_JALR: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.is_jalr     = 1'b1;
            end
            OP_SYSTEM: begin
                ctrl.is_ecall = 1'b1;  // only ECALL is decoded from this group
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  riscv_pkg::word_t instr,
    output riscv_pkg::word_t imm
);
    import riscv_pkg::*;

    opcode_t opcode;

    assign opcode = instr[6:0];

    always_comb begin
        case (opcode)
            OP_ARITH_IMM, OP_LOAD, OP_JALR: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            OP_STORE: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            OP_BRANCH: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            OP_JAL: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                 clk,
    input  logic                 rst,
    input  riscv_pkg::reg_addr_t rs1_addr,
    input  riscv_pkg::reg_addr_t rs2_addr,
    input  riscv_pkg::reg_addr_t rd_addr,
    input  riscv_pkg::reg_addr_t dbg_addr,
    input  riscv_pkg::word_t     rd_data,
    input  logic                 reg_write,
    output riscv_pkg::word_t     rs1_data,
    output riscv_pkg::word_t     rs2_data,
    output riscv_pkg::word_t     dbg_data
);
    import riscv_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (reg_write && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;  // x0 writes are dropped here
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];
    assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];

endmodule

`default_nettype wire

// ==== hw/instr_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_mem (
    input  logic             clk,
    input  logic             load_en,
    input  riscv_pkg::word_t load_addr,
    input  riscv_pkg::word_t load_data,
    input  riscv_pkg::word_t pc,
    output riscv_pkg::word_t instr
);
    import riscv_pkg::*;

    word_t mem [IMEM_WORDS];

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr[IMEM_IDX_W-1:0]] <= load_data;  // load_addr is a word index
        end
    end

    // byte pc to word index, wrapping at the array size
    assign instr = mem[pc[IMEM_IDX_W+1:2]];

endmodule

`default_nettype wire

// ==== hw/data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_mem (
    input  logic             clk,
    input  logic             rst,
    input  riscv_pkg::word_t addr,
    input  riscv_pkg::word_t wdata,
    input  logic             write_en,
    output riscv_pkg::word_t rdata
);
    import riscv_pkg::*;

    logic [DMEM_IDX_W-1:0] idx;
    word_t                 mem [DMEM_WORDS];

    assign idx = addr[DMEM_IDX_W+1:2];  // low two bits ignored, word access only

    always_ff @(posedge clk) begin
        if (rst) begin
            mem <= '{default: '0};
        end else if (write_en) begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = mem[idx];

endmodule

`default_nettype wire

// ==== hw/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load_en,
    input  riscv_pkg::word_t     load_addr,
    input  riscv_pkg::word_t     load_data,
    input  riscv_pkg::reg_addr_t dbg_addr,
    output riscv_pkg::word_t     dbg_data,
    output logic                 halted
);
    import riscv_pkg::*;

    word_t     pc;
    word_t     next_pc;
    word_t     pc_plus_4;
    word_t     pc_plus_imm;
    word_t     instr;
    word_t     imm;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     alu_in_2;
    word_t     alu_result;
    word_t     mem_rdata;
    word_t     load_word;
    word_t     wb_data;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    alu_op_t   alu_op;
    ctrl_t     ctrl;
    logic      bcond;
    logic      commit;
    logic      reg_we;
    logic      mem_we;

    assign rs1           = instr[19:15];
    assign rs2           = instr[24:20];
    assign rd            = instr[11:7];
    assign alu_op.funct7 = instr[31:25];
    assign alu_op.funct3 = instr[14:12];
    assign alu_op.opcode = instr[6:0];

    // an ECALL commits nothing, it only raises halted
    assign commit = !halted && !ctrl.is_ecall;
    assign reg_we = ctrl.reg_write && commit;
    assign mem_we = ctrl.mem_write && commit;

    instr_mem imem_i (
        .clk       (clk),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .pc        (pc),
        .instr     (instr)
    );

    control_unit ctrl_i (
        .opcode (instr[6:0]),
        .ctrl   (ctrl)
    );

    imm_gen imm_i (
        .instr (instr),
        .imm   (imm)
    );

    register_file rf_i (
        .clk       (clk),
        .rst       (rst),
        .rs1_addr  (rs1),
        .rs2_addr  (rs2),
        .rd_addr   (rd),
        .dbg_addr  (dbg_addr),
        .rd_data   (wb_data),
        .reg_write (reg_we),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .dbg_data  (dbg_data)
    );

    assign alu_in_2 = ctrl.alu_src_imm ? imm : rs2_data;

    alu alu_i (
        .alu_op     (alu_op),
        .alu_in_1   (rs1_data),
        .alu_in_2   (alu_in_2),
        .alu_result (alu_result),
        .alu_bcond  (bcond)
    );

    data_mem dmem_i (
        .clk      (clk),
        .rst      (rst),
        .addr     (alu_result),
        .wdata    (rs2_data),
        .write_en (mem_we),
        .rdata    (mem_rdata)
    );

    assign load_word   = ctrl.mem_read ? mem_rdata : '0;
    assign pc_plus_4   = pc + 32'd4;
    assign pc_plus_imm = pc + imm;

    always_comb begin
        if (ctrl.is_jal || ctrl.is_jalr) begin
            wb_data = pc_plus_4;  // link value
        end else if (ctrl.mem_to_reg) begin
            wb_data = load_word;
        end else begin
            wb_data = alu_result;
        end
    end

    always_comb begin
        if (ctrl.is_jalr) begin
            next_pc = {alu_result[31:1], 1'b0};
        end else if (ctrl.is_jal || (ctrl.is_branch && bcond)) begin
            next_pc = pc_plus_imm;
        end else begin
            next_pc = pc_plus_4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= RESET_PC;
            halted <= 1'b0;
        end else begin
            if (commit) begin
                pc <= next_pc;  // pc parks on the ECALL once it is fetched
            end
            if (ctrl.is_ecall) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;  // 100 ns period
        end
    end

endmodule

`default_nettype wire

// ==== dv/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
    import riscv_pkg::*;

    localparam int    PROG_WORDS     = 8;
    localparam int    MAX_TESTS      = 40;
    localparam int    TIMEOUT_CYCLES = 200;
    localparam word_t ECALL          = 32'h0000_0073;

    logic      clk;
    logic      rst;
    logic      load_en;
    word_t     load_addr;
    word_t     load_data;
    reg_addr_t dbg_addr;
    word_t     dbg_data;
    logic      halted;

    word_t     prog_tbl [MAX_TESTS][PROG_WORDS];
    reg_addr_t chk_tbl  [MAX_TESTS];
    word_t     exp_tbl  [MAX_TESTS];
    string     name_tbl [MAX_TESTS];
    int        n_tests;
    int        n_pass;
    int        n_fail;
    word_t     rng;

    clock_gen clk_gen_i (
        .clk (clk)
    );

    cpu cpu_i (
        .clk       (clk),
        .rst       (rst),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .dbg_addr  (dbg_addr),
        .dbg_data  (dbg_data),
        .halted    (halted)
    );

    function automatic word_t r_type(input funct7_t f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input funct3_t f3,
                                     input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OP_ARITH};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                     input funct3_t f3, input reg_addr_t rd,
                                     input opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input funct3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic word_t j_type(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    function automatic word_t lcg_next(input word_t s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    task automatic push_test(input string name, input reg_addr_t chk, input word_t exp,
                             input word_t w0, input word_t w1, input word_t w2,
                             input word_t w3, input word_t w4, input word_t w5,
                             input word_t w6, input word_t w7);
        prog_tbl[n_tests] = '{w0, w1, w2, w3, w4, w5, w6, w7};
        chk_tbl[n_tests]  = chk;
        exp_tbl[n_tests]  = exp;
        name_tbl[n_tests] = name;
        n_tests++;
    endtask

    // x1 = a, x2 = b, x3 = x1 op x2
    task automatic rr_case(input string name, input funct7_t f7, input funct3_t f3,
                           input logic [11:0] a, input logic [11:0] b, input word_t exp);
        push_test(name, 5'd3, exp,
                  i_type(a, 5'd0, F3_ADD, 5'd1, OP_ARITH_IMM),
                  i_type(b, 5'd0, F3_ADD, 5'd2, OP_ARITH_IMM),
                  r_type(f7, 5'd2, 5'd1, f3, 5'd3),
                  ECALL, ECALL, ECALL, ECALL, ECALL);
    endtask

    task automatic imm_case(input string name, input logic [11:0] a, input funct3_t f3,
                            input logic [11:0] imm, input word_t exp);
        push_test(name, 5'd2, exp,
                  i_type(a, 5'd0, F3_ADD, 5'd1, OP_ARITH_IMM),
                  i_type(imm, 5'd1, f3, 5'd2, OP_ARITH_IMM),
                  ECALL, ECALL, ECALL, ECALL, ECALL, ECALL);
    endtask

    // taken skips the first addi, so x5 ends at 2 when taken and 3 when not
    task automatic branch_case(input string name, input funct3_t f3, input logic [11:0] a,
                               input logic [11:0] b, input word_t exp);
        push_test(name, 5'd5, exp,
                  i_type(a, 5'd0, F3_ADD, 5'd1, OP_ARITH_IMM),
                  i_type(b, 5'd0, F3_ADD, 5'd2, OP_ARITH_IMM),
                  b_type(13'd8, 5'd2, 5'd1, f3),
                  i_type(12'd1, 5'd0, F3_ADD, 5'd5, OP_ARITH_IMM),
                  i_type(12'd2, 5'd5, F3_ADD, 5'd5, OP_ARITH_IMM),
                  ECALL, ECALL, ECALL);
    endtask

    task automatic build_table();
        int          k;
        logic [11:0] ra;
        logic [11:0] rb;
        rr_case("add", 7'h00, F3_ADD, 12'd100, 12'hFF9, 32'h0000_005D);
        rr_case("sub", F7_SUB_SRA, F3_ADD, 12'd100, 12'hFF9, 32'h0000_006B);
        rr_case("xor", 7'h00, F3_XOR, 12'h5A5, 12'h0F0, 32'h0000_0555);
        rr_case("or", 7'h00, F3_OR, 12'h5A5, 12'h0F0, 32'h0000_05F5);
        rr_case("and", 7'h00, F3_AND, 12'h5A5, 12'h0F0, 32'h0000_00A0);
        rr_case("sll", 7'h00, F3_SLL, 12'h123, 12'd8, 32'h0001_2300);
        rr_case("srl", 7'h00, F3_SRL, 12'hF00, 12'd4, 32'h0FFF_FFF0);
        rr_case("sra", F7_SUB_SRA, F3_SRL, 12'hF00, 12'd4, 32'hFFFF_FFF0);
        imm_case("addi neg", 12'd5, F3_ADD, 12'hFF4, 32'hFFFF_FFF9);
        imm_case("xori", 12'h0FF, F3_XOR, 12'hFFF, 32'hFFFF_FF00);
        imm_case("ori", 12'h0F0, F3_OR, 12'h70F, 32'h0000_07FF);
        imm_case("andi", 12'hFFF, F3_AND, 12'h5A5, 32'h0000_05A5);
        imm_case("slli", 12'd1, F3_SLL, 12'h01F, 32'h8000_0000);
        imm_case("srli", 12'hFFF, F3_SRL, 12'h01C, 32'h0000_000F);
        imm_case("srai", 12'h800, F3_SRL, 12'h404, 32'hFFFF_FF80);
        push_test("sw lw", 5'd3, 32'h0000_0123,
                  i_type(12'h123, 5'd0, F3_ADD, 5'd1, OP_ARITH_IMM),
                  i_type(12'd40, 5'd0, F3_ADD, 5'd2, OP_ARITH_IMM),
                  s_type(12'd8, 5'd1, 5'd2),
                  i_type(12'd8, 5'd2, 3'b010, 5'd3, OP_LOAD),
                  ECALL, ECALL, ECALL, ECALL);
        // address 48 held a word from the test above until reset cleared it
        push_test("lw unwritten", 5'd3, 32'h0000_0000,
                  i_type(12'd7, 5'd0, F3_ADD, 5'd3, OP_ARITH_IMM),
                  i_type(12'd48, 5'd0, 3'b010, 5'd3, OP_LOAD),
                  ECALL, ECALL, ECALL, ECALL, ECALL, ECALL);
        branch_case("beq taken", F3_BEQ, 12'd5, 12'd5, 32'd2);
        branch_case("beq not taken", F3_BEQ, 12'd5, 12'd6, 32'd3);
        branch_case("bne taken", F3_BNE, 12'd5, 12'd6, 32'd2);
        branch_case("bne not taken", F3_BNE, 12'd5, 12'd5, 32'd3);
        branch_case("blt taken", F3_BLT, 12'hFFF, 12'd1, 32'd2);
        branch_case("blt not taken", F3_BLT, 12'd1, 12'hFFF, 32'd3);
        branch_case("bge taken", F3_BGE, 12'd1, 12'hFFF, 32'd2);
        branch_case("bge not taken", F3_BGE, 12'hFFF, 12'd1, 32'd3);
        push_test("jal link", 5'd1, 32'h0000_0004,
                  j_type(21'd8, 5'd1),
                  i_type(12'd99, 5'd0, F3_ADD, 5'd1, OP_ARITH_IMM),
                  ECALL, ECALL, ECALL, ECALL, ECALL, ECALL);
        for (k = 0; k < 2; k++) begin
            // jalr at pc 4 lands on pc 16, the last addi
            push_test(k == 0 ? "jalr link" : "jalr target", k == 0 ? 5'd2 : 5'd3,
                      k == 0 ? 32'h0000_0008 : 32'h0000_0005,
                      i_type(12'd12, 5'd0, F3_ADD, 5'd1, OP_ARITH_IMM),
                      i_type(12'd4, 5'd1, 3'b000, 5'd2, OP_JALR),
                      i_type(12'd1, 5'd0, F3_ADD, 5'd3, OP_ARITH_IMM),
                      i_type(12'd2, 5'd0, F3_ADD, 5'd3, OP_ARITH_IMM),
                      i_type(12'd5, 5'd3, F3_ADD, 5'd3, OP_ARITH_IMM),
                      ECALL, ECALL, ECALL);
        end
        push_test("x0 write", 5'd4, 32'h0000_0003,
                  i_type(12'd55, 5'd0, F3_ADD, 5'd0, OP_ARITH_IMM),
                  i_type(12'd3, 5'd0, F3_ADD, 5'd4, OP_ARITH_IMM),
                  r_type(7'h00, 5'd0, 5'd4, F3_ADD, 5'd4),
                  ECALL, ECALL, ECALL, ECALL, ECALL);
        for (k = 0; k < 4; k++) begin
            rng = lcg_next(rng);
            ra  = rng[27:16];
            rng = lcg_next(rng);
            rb  = rng[27:16];
            rng = lcg_next(rng);
            if (rng[20]) begin
                rr_case("rand sub", F7_SUB_SRA, F3_ADD, ra, rb, sext12(ra) - sext12(rb));
            end else begin
                rr_case("rand add", 7'h00, F3_ADD, ra, rb, sext12(ra) + sext12(rb));
            end
        end
    endtask

    initial begin
        int t;
        int i;
        int cycles;
        rst       = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        dbg_addr  = '0;
        n_tests   = 0;
        n_pass    = 0;
        n_fail    = 0;
        rng       = 32'd55;
        build_table();
        repeat (3) @(posedge clk);
        #1;
        for (t = 0; t < n_tests; t++) begin
            rst = 1'b1;
            for (i = 0; i < IMEM_WORDS; i++) begin
                load_en   = 1'b1;
                load_addr = word_t'(i);
                load_data = (i < PROG_WORDS) ? prog_tbl[t][i] : ECALL;
                @(posedge clk);
                #1;
            end
            load_en  = 1'b0;
            dbg_addr = chk_tbl[t];
            rst      = 1'b0;
            cycles   = 0;
            while (!halted && cycles < TIMEOUT_CYCLES) begin
                @(posedge clk);
                #1;
                cycles++;
            end
            if (!halted) begin
                $display("%s: core never halted within %0d cycles", name_tbl[t], TIMEOUT_CYCLES);
                n_fail++;
            end else if (dbg_data !== exp_tbl[t]) begin
                $display("ERR %s: dbg_data x%0d expected %08h actual %08h",
                         name_tbl[t], chk_tbl[t], exp_tbl[t], dbg_data);
                n_fail++;
            end else begin
                $display("ok %s: x%0d = %08h after %0d cycles",
                         name_tbl[t], chk_tbl[t], dbg_data, cycles);
                n_pass++;
            end
        end
        $display("tests done: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/riscv_pkg.sv
hw/alu.sv
hw/control_unit.sv
hw/imm_gen.sv
hw/register_file.sv
hw/instr_mem.sv
hw/data_mem.sv
hw/cpu.sv
dv/clock_gen.sv
dv/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module cpu_tb -f verilog.f -o cpu_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/cpu_tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qxF "PASS: all tests"; then
    exit 0
fi
exit 1
